// ==== rtl/bht.sv ====
`timescale 1ns/1ns

module bht (
  input logic clk_i,
  input logic rst_ni,
  bht_if.tbl  bus
);

  // one valid bit and one 2-bit counter per entry
  logic [fetch_pkg::bht_entries-1:0] valid_q;
  logic [1:0]                        cnt_q [fetch_pkg::bht_entries];
  logic [1:0]                        upd_cnt;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  // combinational read, weakly taken and up count as taken
  assign bus.lookup_valid = valid_q[bus.lookup_idx];
  assign bus.lookup_taken = cnt_q[bus.lookup_idx][1];

  // ----------------------------------------
  // update
  // ----------------------------------------
  // current counter of the entry being trained
  assign upd_cnt = cnt_q[bus.update_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (bus.update_valid) begin
      valid_q[bus.update_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.update_valid) begin
      if (!valid_q[bus.update_idx]) begin
        // first sighting starts weak in the resolved direction
        cnt_q[bus.update_idx] <= bus.update_taken ? 2'd2 : 2'd1;
      end else if (bus.update_taken) begin
        // saturate at strongly taken
        if (upd_cnt != 2'd3) begin
          cnt_q[bus.update_idx] <= upd_cnt + 2'd1;
        end
      end else begin
        // saturate at strongly not taken
        if (upd_cnt != 2'd0) begin
          cnt_q[bus.update_idx] <= upd_cnt - 2'd1;
        end
      end
    end
  end

endmodule

// ==== rtl/bht_if.sv ====
`timescale 1ns/1ns

interface bht_if;

  // lookup for the word currently coming back from memory
  fetch_pkg::bht_idx_t lookup_idx;
  logic                lookup_valid;
  logic                lookup_taken;

  // training from a resolved conditional branch
  logic                update_valid;
  fetch_pkg::bht_idx_t update_idx;
  logic                update_taken;

  // predictor side drives the index and the update
  modport predictor (
    output lookup_idx,
    input  lookup_valid,
    input  lookup_taken,
    output update_valid,
    output update_idx,
    output update_taken
  );

  // table side answers the lookup and takes the update
  modport tbl (
    input  lookup_idx,
    output lookup_valid,
    output lookup_taken,
    input  update_valid,
    input  update_idx,
    input  update_taken
  );

endinterface

// ==== rtl/branch_predict.sv ====
`timescale 1ns/1ns

module branch_predict (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    imem_rvalid_i,
  input  fetch_pkg::instr_t       imem_rdata_i,
  input  fetch_pkg::addr_t        rsp_pc_i,
  input  logic                    rsp_keep_i,
  input  fetch_pkg::resolve_t     resolve_i,
  output logic                    push_valid_o,
  output fetch_pkg::fetch_entry_t push_entry_o,
  output logic                    pred_redirect_o,
  output fetch_pkg::addr_t        pred_target_o
);

  fetch_pkg::addr_t rsp_pc_q;
  fetch_pkg::addr_t jal_imm;
  fetch_pkg::addr_t br_imm;
  fetch_pkg::addr_t target;
  logic             is_jal;
  logic             is_branch;
  logic             taken;

  bht_if u_bht_if ();

  bht u_bht (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .bus   (u_bht_if.tbl)
  );

  // address of the request in flight, any response belongs to last cycle
  always_ff @(posedge clk_i) begin
    rsp_pc_q <= rsp_pc_i;
  end

  // ----------------------------------------
  // scan
  // ----------------------------------------
  assign is_jal    = imem_rdata_i[6:0] == fetch_pkg::opc_jal;
  assign is_branch = imem_rdata_i[6:0] == fetch_pkg::opc_branch;

  // j-type and b-type immediates, sign extended
  assign jal_imm = {{12{imem_rdata_i[31]}}, imem_rdata_i[19:12], imem_rdata_i[20],
                    imem_rdata_i[30:21], 1'b0};
  assign br_imm  = {{20{imem_rdata_i[31]}}, imem_rdata_i[7], imem_rdata_i[30:25],
                    imem_rdata_i[11:8], 1'b0};

  assign target = rsp_pc_q + (is_jal ? jal_imm : br_imm);

  // history lookup on the response address
  assign u_bht_if.lookup_idx = rsp_pc_q[fetch_pkg::bht_idx_w+1:2];

  // jal always, branch by history or else backward taken
  always_comb begin
    taken = 1'b0;
    if (is_jal) begin
      taken = 1'b1;
    end else if (is_branch) begin
      taken = u_bht_if.lookup_valid ? u_bht_if.lookup_taken : br_imm[fetch_pkg::xlen-1];
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  // killed responses neither push nor redirect
  assign push_valid_o    = imem_rvalid_i && rsp_keep_i;
  assign pred_redirect_o = push_valid_o && taken;
  assign pred_target_o   = target;

  assign push_entry_o.pc          = rsp_pc_q;
  assign push_entry_o.instr       = imem_rdata_i;
  assign push_entry_o.pred_taken  = taken;
  // not taken falls through to the next word
  assign push_entry_o.pred_target = taken ? target : rsp_pc_q + 32'd4;

  // train on conditional branches only
  assign u_bht_if.update_valid = resolve_i.valid && resolve_i.is_branch;
  assign u_bht_if.update_idx   = resolve_i.pc[fetch_pkg::bht_idx_w+1:2];
  assign u_bht_if.update_taken = resolve_i.taken;

endmodule

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

  // ----------------------------------------
  // widths and sizes
  // ----------------------------------------
  // address and instruction width, rv32 without compressed
  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] addr_t;
  typedef logic [xlen-1:0] instr_t;

  // history table, indexed by word address bits above the byte offset
  localparam int unsigned bht_entries = 16;
  localparam int unsigned bht_idx_w   = $clog2(bht_entries);

  typedef logic [bht_idx_w-1:0] bht_idx_t;

  // fetch queue toward decode
  localparam int unsigned queue_depth = 4;
  localparam int unsigned queue_ptr_w = $clog2(queue_depth);
  localparam int unsigned queue_cnt_w = $clog2(queue_depth + 1);

  typedef logic [queue_ptr_w-1:0] queue_ptr_t;
  typedef logic [queue_cnt_w-1:0] queue_cnt_t;

  // major opcodes seen by the scanner
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // ----------------------------------------
  // shared structs
  // ----------------------------------------
  // branch resolved in the backend
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  is_branch;
    logic  taken;
    logic  mispredict;
    addr_t target;
  } resolve_t;

  // one instruction handed to decode
  typedef struct packed {
    addr_t  pc;
    instr_t instr;
    logic   pred_taken;
    addr_t  pred_target;
  } fetch_entry_t;

endpackage

// ==== rtl/fetch_queue.sv ====
`timescale 1ns/1ns

module fetch_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ex_valid_i,
  input  logic                    eret_i,
  input  fetch_pkg::resolve_t     resolve_i,
  input  logic                    push_valid_i,
  input  fetch_pkg::fetch_entry_t push_entry_i,
  output logic                    has_room_o,
  output logic                    pop_valid_o,
  output fetch_pkg::fetch_entry_t pop_entry_o,
  input  logic                    pop_ready_i
);

  fetch_pkg::fetch_entry_t mem_q [fetch_pkg::queue_depth];
  fetch_pkg::queue_ptr_t   wr_ptr_q;
  fetch_pkg::queue_ptr_t   rd_ptr_q;
  fetch_pkg::queue_cnt_t   count_q;
  logic                    flush;
  logic                    full;
  logic                    push;
  logic                    pop;

  // wrap at the last slot
  function automatic fetch_pkg::queue_ptr_t next_ptr(input fetch_pkg::queue_ptr_t ptr);
    fetch_pkg::queue_ptr_t nxt;
    if (ptr == fetch_pkg::queue_ptr_t'(fetch_pkg::queue_depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ----------------------------------------
  // status
  // ----------------------------------------
  // backend redirect empties the queue
  assign flush = ex_valid_i || eret_i || (resolve_i.valid && resolve_i.mispredict);
  assign full  = count_q == fetch_pkg::queue_cnt_t'(fetch_pkg::queue_depth);

  // two free slots cover the response already in flight
  assign has_room_o = count_q <= fetch_pkg::queue_cnt_t'(fetch_pkg::queue_depth - 2);

  // no bypass, a new entry shows one cycle after its write
  assign pop_valid_o = count_q != '0;
  assign pop_entry_o = mem_q[rd_ptr_q];

  assign push = push_valid_i && !flush;
  assign pop  = pop_valid_o && pop_ready_i && !flush;

  // ----------------------------------------
  // pointers and storage
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // count moves only when exactly one side fires
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  // room check in npc_gen keeps a response from landing on a full queue
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_valid_i |-> !full
  );

endmodule

// ==== rtl/frontend_top.sv ====
`timescale 1ns/1ns

module frontend_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  fetch_pkg::addr_t  boot_addr_i,
  // instruction memory
  output logic              imem_req_o,
  output fetch_pkg::addr_t  imem_addr_o,
  input  logic              imem_gnt_i,
  input  logic              imem_rvalid_i,
  input  fetch_pkg::instr_t imem_rdata_i,
  // backend
  input  logic              ex_valid_i,
  input  fetch_pkg::addr_t  trap_vector_i,
  input  logic              eret_i,
  input  fetch_pkg::addr_t  epc_i,
  input  logic              resolve_valid_i,
  input  fetch_pkg::addr_t  resolve_pc_i,
  input  logic              resolve_is_branch_i,
  input  logic              resolve_taken_i,
  input  logic              resolve_mispredict_i,
  input  fetch_pkg::addr_t  resolve_target_i,
  // decode
  output logic              fetch_valid_o,
  input  logic              fetch_ready_i,
  output fetch_pkg::addr_t  fetch_pc_o,
  output fetch_pkg::instr_t fetch_instr_o,
  output logic              fetch_pred_taken_o,
  output fetch_pkg::addr_t  fetch_pred_target_o
);

  fetch_pkg::resolve_t     resolve;
  fetch_pkg::fetch_entry_t push_entry;
  fetch_pkg::fetch_entry_t pop_entry;
  fetch_pkg::addr_t        pred_target;
  logic                    push_valid;
  logic                    pred_redirect;
  logic                    rsp_keep;
  logic                    has_room;

  // resolve ports into one struct
  assign resolve.valid      = resolve_valid_i;
  assign resolve.pc         = resolve_pc_i;
  assign resolve.is_branch  = resolve_is_branch_i;
  assign resolve.taken      = resolve_taken_i;
  assign resolve.mispredict = resolve_mispredict_i;
  assign resolve.target     = resolve_target_i;

  npc_gen u_npc_gen (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .ex_valid_i     (ex_valid_i),
    .trap_vector_i  (trap_vector_i),
    .eret_i         (eret_i),
    .epc_i          (epc_i),
    .resolve_i      (resolve),
    .pred_redirect_i(pred_redirect),
    .pred_target_i  (pred_target),
    .has_room_i     (has_room),
    .imem_req_o     (imem_req_o),
    .imem_addr_o    (imem_addr_o),
    .imem_gnt_i     (imem_gnt_i),
    .rsp_keep_o     (rsp_keep)
  );

  // request address is captured inside for the response
  branch_predict u_branch_predict (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .imem_rvalid_i  (imem_rvalid_i),
    .imem_rdata_i   (imem_rdata_i),
    .rsp_pc_i       (imem_addr_o),
    .rsp_keep_i     (rsp_keep),
    .resolve_i      (resolve),
    .push_valid_o   (push_valid),
    .push_entry_o   (push_entry),
    .pred_redirect_o(pred_redirect),
    .pred_target_o  (pred_target)
  );

  fetch_queue u_fetch_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ex_valid_i  (ex_valid_i),
    .eret_i      (eret_i),
    .resolve_i   (resolve),
    .push_valid_i(push_valid),
    .push_entry_i(push_entry),
    .has_room_o  (has_room),
    .pop_valid_o (fetch_valid_o),
    .pop_entry_o (pop_entry),
    .pop_ready_i (fetch_ready_i)
  );

  // queue head out to decode
  assign fetch_pc_o          = pop_entry.pc;
  assign fetch_instr_o       = pop_entry.instr;
  assign fetch_pred_taken_o  = pop_entry.pred_taken;
  assign fetch_pred_target_o = pop_entry.pred_target;

endmodule

// ==== rtl/npc_gen.sv ====
`timescale 1ns/1ns

module npc_gen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  fetch_pkg::addr_t     boot_addr_i,
  input  logic                 ex_valid_i,
  input  fetch_pkg::addr_t     trap_vector_i,
  input  logic                 eret_i,
  input  fetch_pkg::addr_t     epc_i,
  input  fetch_pkg::resolve_t  resolve_i,
  input  logic                 pred_redirect_i,
  input  fetch_pkg::addr_t     pred_target_i,
  input  logic                 has_room_i,
  output logic                 imem_req_o,
  output fetch_pkg::addr_t     imem_addr_o,
  input  logic                 imem_gnt_i,
  output logic                 rsp_keep_o
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t npc_d;
  fetch_pkg::addr_t fetch_addr;
  logic             boot_load_q;
  logic             accept;
  logic             mispredict;
  logic             be_redirect;
  logic             want_d;
  logic             want_q;

  // ----------------------------------------
  // request side
  // ----------------------------------------
  // first cycle out of reset only loads the boot address
  assign fetch_addr  = boot_load_q ? boot_addr_i : pc_q;
  assign imem_req_o  = !boot_load_q && has_room_i;
  assign imem_addr_o = fetch_addr;
  assign accept      = imem_req_o && imem_gnt_i;

  // backend redirect, same decode as in the queue
  assign mispredict  = resolve_i.valid && resolve_i.mispredict;
  assign be_redirect = ex_valid_i || eret_i || mispredict;

  // next pc, lowest priority first so later lines win
  always_comb begin
    npc_d = fetch_addr;
    if (accept) begin
      npc_d = fetch_addr + 32'd4;
    end
    if (pred_redirect_i) begin
      npc_d = pred_target_i;
    end
    if (mispredict) begin
      npc_d = resolve_i.target;
    end
    if (eret_i) begin
      npc_d = epc_i;
    end
    if (ex_valid_i) begin
      npc_d = trap_vector_i;
    end
  end

  // ----------------------------------------
  // kill of stale responses
  // ----------------------------------------
  // accepted request stays wanted only if nothing changes the flow now
  assign want_d     = accept && !be_redirect && !pred_redirect_i;
  // response shows up one cycle after accept
  assign rsp_keep_o = want_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_load_q <= 1'b1;
      pc_q        <= '0;
      want_q      <= 1'b0;
    end else begin
      boot_load_q <= 1'b0;
      pc_q        <= npc_d;
      want_q      <= want_d;
    end
  end

  // queue needs two free slots before each new request
  a_req_needs_room : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    imem_req_o |-> has_room_i
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_frontend -f src.f -Mdir obj_dir -o tb_frontend > build.log 2>&1 \
  && ./obj_dir/tb_frontend > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Testbench passed" sim.log && exit 0 || exit 1

// ==== sim/tb_frontend.sv ====
`timescale 1ns/1ns

module tb_frontend;

  localparam int unsigned clk_period = 40;
  localparam int unsigned n_steps    = 10;
  localparam int unsigned n_prog     = 5;
  localparam int unsigned max_exp    = 16;
  localparam fetch_pkg::addr_t boot_addr = 32'h0000_0100;

  // how a test starts
  localparam int kind_none       = 0;
  localparam int kind_trap       = 1;
  localparam int kind_trap_eret  = 2;
  localparam int kind_mispredict = 3;
  localparam int kind_resolve    = 4;

  // target is trap vector or resolve target, alt is epc or resolved pc
  typedef struct {
    string            name;
    int               kind;
    fetch_pkg::addr_t target;
    fetch_pkg::addr_t alt;
    logic             taken;
    int               n_entries;
    logic             rand_ready;
  } step_t;

  logic              clk_i;
  logic              rst_ni;
  logic              imem_req_o;
  fetch_pkg::addr_t  imem_addr_o;
  logic              imem_gnt_i;
  logic              imem_rvalid_i;
  fetch_pkg::instr_t imem_rdata_i;
  logic              ex_valid_i;
  fetch_pkg::addr_t  trap_vector_i;
  logic              eret_i;
  fetch_pkg::addr_t  epc_i;
  logic              resolve_valid_i;
  fetch_pkg::addr_t  resolve_pc_i;
  logic              resolve_is_branch_i;
  logic              resolve_taken_i;
  logic              resolve_mispredict_i;
  fetch_pkg::addr_t  resolve_target_i;
  logic              fetch_valid_o;
  logic              fetch_ready_i;
  fetch_pkg::addr_t  fetch_pc_o;
  fetch_pkg::instr_t fetch_instr_o;
  logic              fetch_pred_taken_o;
  fetch_pkg::addr_t  fetch_pred_target_o;

  step_t             steps [n_steps];
  fetch_pkg::addr_t  prog_addr [n_prog];
  fetch_pkg::instr_t prog_word [n_prog];
  // branch or jump offset each program word is built from
  int                prog_off [n_prog];

  // expected entries of the running test
  fetch_pkg::addr_t  exp_pc [max_exp];
  fetch_pkg::instr_t exp_instr [max_exp];
  logic              exp_taken [max_exp];
  fetch_pkg::addr_t  exp_target [max_exp];

  // reference history table
  logic              hist_valid [fetch_pkg::bht_entries];
  int                hist_cnt [fetch_pkg::bht_entries];

  logic [31:0]       lcg_state;
  logic [31:0]       rnd;
  logic              rsp_pending;
  fetch_pkg::addr_t  rsp_addr;
  int                cycles;
  int                cycle_limit;
  int                cur_step;
  int                got;
  int                n_exp;
  int                checks;
  int                errors;
  int                step_errors;
  int                failed_tests;

  frontend_top u_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr),
    .imem_req_o          (imem_req_o),
    .imem_addr_o         (imem_addr_o),
    .imem_gnt_i          (imem_gnt_i),
    .imem_rvalid_i       (imem_rvalid_i),
    .imem_rdata_i        (imem_rdata_i),
    .ex_valid_i          (ex_valid_i),
    .trap_vector_i       (trap_vector_i),
    .eret_i              (eret_i),
    .epc_i               (epc_i),
    .resolve_valid_i     (resolve_valid_i),
    .resolve_pc_i        (resolve_pc_i),
    .resolve_is_branch_i (resolve_is_branch_i),
    .resolve_taken_i     (resolve_taken_i),
    .resolve_mispredict_i(resolve_mispredict_i),
    .resolve_target_i    (resolve_target_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_pc_o          (fetch_pc_o),
    .fetch_instr_o       (fetch_instr_o),
    .fetch_pred_taken_o  (fetch_pred_taken_o),
    .fetch_pred_target_o (fetch_pred_target_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // cycle budget for the whole run
  initial begin
    wait (cycles > cycle_limit);
    $display("timeout after %0d cycles in test %0d with %0d of %0d entries seen",
             cycles, cur_step, got, n_exp);
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------
  // instruction encoding and memory content
  // ----------------------------------------
  function automatic fetch_pkg::instr_t encode_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, fetch_pkg::opc_jal};
  endfunction

  function automatic fetch_pkg::instr_t encode_branch(input logic [2:0] f3,
      input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], fetch_pkg::opc_branch};
  endfunction

  // addi x0 with an immediate folded from the address, else a program word
  function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t addr);
    fetch_pkg::instr_t word;
    logic [11:0]       imm;
    imm  = addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]} ^ {10'd0, addr[1:0]};
    word = {imm, 5'd0, 3'b000, 5'd0, 7'b0010011};
    for (int i = 0; i < n_prog; i++) begin
      if (prog_addr[i] == addr) begin
        word = prog_word[i];
      end
    end
    return word;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // offset the program table placed at this address
  function automatic int prog_offset(input fetch_pkg::addr_t addr);
    int off;
    off = 0;
    for (int i = 0; i < n_prog; i++) begin
      if (prog_addr[i] == addr) begin
        off = prog_off[i];
      end
    end
    return off;
  endfunction

  // two-bit counter, new entries start weak in the resolved direction
  task automatic train_history(input fetch_pkg::addr_t pc, input logic taken);
    fetch_pkg::bht_idx_t idx;
    idx = pc[5:2];
    if (!hist_valid[idx]) begin
      hist_cnt[idx] = taken ? 2 : 1;
    end else if (taken && hist_cnt[idx] != 3) begin
      hist_cnt[idx] = hist_cnt[idx] + 1;
    end else if (!taken && hist_cnt[idx] != 0) begin
      hist_cnt[idx] = hist_cnt[idx] - 1;
    end
    hist_valid[idx] = 1'b1;
  endtask

  // walk the program flow the way decode should see it
  task automatic build_expected(input fetch_pkg::addr_t start, input int n);
    fetch_pkg::addr_t    pc;
    fetch_pkg::instr_t   w;
    fetch_pkg::bht_idx_t idx;
    int                  off;
    logic                taken;
    pc = start;
    for (int i = 0; i < n; i++) begin
      w     = mem_word(pc);
      taken = 1'b0;
      off   = 4;
      idx   = pc[5:2];
      if (w[6:0] == fetch_pkg::opc_jal) begin
        taken = 1'b1;
        off   = prog_offset(pc);
      end else if (w[6:0] == fetch_pkg::opc_branch) begin
        off   = prog_offset(pc);
        // no history means backward taken
        taken = hist_valid[idx] ? (hist_cnt[idx] >= 2) : (off < 0);
        if (!taken) begin
          off = 4;
        end
      end
      exp_pc[i]     = pc;
      exp_instr[i]  = w;
      exp_taken[i]  = taken;
      exp_target[i] = pc + fetch_pkg::addr_t'(off);
      pc            = exp_target[i];
    end
  endtask

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic check_addr(input string name, input fetch_pkg::addr_t act,
      input fetch_pkg::addr_t exp);
    checks++;
    if (act !== exp) begin
      $display("mismatch %s at entry %0d: got 0x%08h, expected 0x%08h", name, got, act, exp);
      errors++;
      step_errors++;
    end
  endtask

  task automatic check_instr(input string name, input fetch_pkg::instr_t act,
      input fetch_pkg::instr_t exp);
    checks++;
    if (act !== exp) begin
      $display("mismatch %s at entry %0d: got 0x%08h, expected 0x%08h", name, got, act, exp);
      errors++;
      step_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      $display("mismatch %s at entry %0d: got 0x%0h, expected 0x%0h", name, got, act, exp);
      errors++;
      step_errors++;
    end
  endtask

  // ----------------------------------------
  // cycle handling
  // ----------------------------------------
  // memory side, driven shortly after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    #5;
    cycles++;
    rnd           = lcg_next();
    imem_gnt_i    = rnd[17:16] != 2'b00;
    imem_rvalid_i = rsp_pending;
    imem_rdata_i  = rsp_pending ? mem_word(rsp_addr) : 32'h0;
  endtask

  // late in the cycle everything has settled
  task automatic sample_cycle();
    #30;
    rsp_pending = imem_req_o && imem_gnt_i;
    rsp_addr    = imem_addr_o;
    if (fetch_valid_o && fetch_ready_i) begin
      check_addr("fetch_pc_o", fetch_pc_o, exp_pc[got]);
      check_instr("fetch_instr_o", fetch_instr_o, exp_instr[got]);
      check_bit("fetch_pred_taken_o", fetch_pred_taken_o, exp_taken[got]);
      check_addr("fetch_pred_target_o", fetch_pred_target_o, exp_target[got]);
      got++;
    end
  endtask

  task automatic apply_step(input step_t st);
    ex_valid_i           = st.kind == kind_trap || st.kind == kind_trap_eret;
    trap_vector_i        = st.target;
    eret_i               = st.kind == kind_trap_eret;
    epc_i                = st.alt;
    resolve_valid_i      = st.kind == kind_mispredict || st.kind == kind_resolve;
    resolve_pc_i         = st.alt;
    resolve_is_branch_i  = st.kind == kind_resolve;
    resolve_taken_i      = st.taken;
    resolve_mispredict_i = st.kind == kind_mispredict;
    resolve_target_i     = st.target;
    // decode holds off while the frontend turns around
    fetch_ready_i        = 1'b0;
  endtask

  task automatic clear_backend();
    ex_valid_i           = 1'b0;
    eret_i               = 1'b0;
    resolve_valid_i      = 1'b0;
    resolve_is_branch_i  = 1'b0;
    resolve_mispredict_i = 1'b0;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    fetch_pkg::addr_t start;
    int               total;
    rst_ni           = 1'b0;
    imem_gnt_i       = 1'b0;
    imem_rvalid_i    = 1'b0;
    imem_rdata_i     = '0;
    trap_vector_i    = '0;
    epc_i            = '0;
    resolve_pc_i     = '0;
    resolve_taken_i  = 1'b0;
    resolve_target_i = '0;
    clear_backend();
    fetch_ready_i    = 1'b0;
    lcg_state        = 32'd89;
    rsp_pending      = 1'b0;
    rsp_addr         = '0;
    cycles           = 0;
    got              = 0;
    n_exp            = 0;
    checks           = 0;
    errors           = 0;
    failed_tests     = 0;
    cur_step         = 0;
    for (int i = 0; i < fetch_pkg::bht_entries; i++) begin
      hist_valid[i] = 1'b0;
      hist_cnt[i]   = 0;
    end

    prog_addr[0] = 32'h200;
    prog_off[0]  = 'h40;
    prog_word[0] = encode_jal(21'(prog_off[0]));
    prog_addr[1] = 32'h308;
    prog_off[1]  = -8;
    prog_word[1] = encode_branch(3'b000, 5'd0, 5'd0, 13'(prog_off[1]));
    prog_addr[2] = 32'h400;
    prog_off[2]  = 'h20;
    prog_word[2] = encode_branch(3'b001, 5'd1, 5'd2, 13'(prog_off[2]));
    prog_addr[3] = 32'h500;
    prog_off[3]  = 'h30;
    prog_word[3] = encode_branch(3'b100, 5'd3, 5'd4, 13'(prog_off[3]));
    prog_addr[4] = 32'h810;
    prog_off[4]  = 'hf0;
    prog_word[4] = encode_jal(21'(prog_off[4]));

    // name, kind, target, alt, taken, entries, random ready
    steps[0] = '{"boot sequential", kind_none, 32'h0, 32'h0, 1'b0, 6, 1'b0};
    steps[1] = '{"jal taken", kind_trap, 32'h1f8, 32'h0, 1'b0, 5, 1'b0};
    steps[2] = '{"backward branch", kind_trap, 32'h300, 32'h0, 1'b0, 6, 1'b0};
    steps[3] = '{"forward branch", kind_trap, 32'h400, 32'h0, 1'b0, 3, 1'b0};
    steps[4] = '{"resolve taken 1", kind_resolve, 32'h0, 32'h500, 1'b1, 0, 1'b0};
    steps[5] = '{"resolve taken 2", kind_resolve, 32'h0, 32'h500, 1'b1, 0, 1'b0};
    steps[6] = '{"trained branch", kind_trap, 32'h500, 32'h0, 1'b0, 3, 1'b0};
    steps[7] = '{"trap over eret", kind_trap_eret, 32'h600, 32'h700, 1'b0, 3, 1'b0};
    steps[8] = '{"mispredict", kind_mispredict, 32'h680, 32'h60c, 1'b0, 3, 1'b0};
    steps[9] = '{"back-pressure", kind_trap, 32'h800, 32'h0, 1'b0, 12, 1'b1};

    total = 0;
    for (int s = 0; s < n_steps; s++) begin
      total = total + steps[s].n_entries;
    end
    cycle_limit = 40 * total + 200;

    repeat (8) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;

    for (int s = 0; s < n_steps; s++) begin
      cur_step    = s;
      step_errors = 0;
      got         = 0;
      n_exp       = steps[s].n_entries;
      if (steps[s].kind == kind_resolve) begin
        train_history(steps[s].alt, steps[s].taken);
      end
      start = (steps[s].kind == kind_none) ? boot_addr : steps[s].target;
      build_expected(start, n_exp);

      next_cycle();
      apply_step(steps[s]);
      sample_cycle();
      while (got < n_exp) begin
        next_cycle();
        clear_backend();
        // about half the cycles stall under back-pressure
        fetch_ready_i = steps[s].rand_ready ? rnd[22] : 1'b1;
        sample_cycle();
      end

      if (step_errors != 0) begin
        failed_tests++;
      end
      $display("test %0d %s: %0d of %0d entries, %0d errors",
               s, steps[s].name, got, n_exp, step_errors);
    end

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d, cycles %0d",
             n_steps, failed_tests, checks, errors, cycles);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rtl/fetch_pkg.sv
rtl/bht_if.sv
rtl/bht.sv
rtl/branch_predict.sv
rtl/npc_gen.sv
rtl/fetch_queue.sv
rtl/frontend_top.sv
sim/tb_frontend.sv
